// ==== stream_merge_testdata.txt ====
# stream merger test vectors
# test <name> <mode 0 fixed, 1 round robin, 2 both> <stall mask hex> <hold cycles> <random>
# beat <source> <data hex> | gen <beats per source> | expect <source> <data hex> | run
test single_src1 2 00 0 0
beat 1 1a01
beat 1 1a02
beat 1 1a03
beat 1 1a04
beat 1 1a05
run
test prio_fixed 0 00 20 0
beat 3 3c00
beat 2 2c00
beat 1 1c00
beat 0 0c00
expect 0 0c00
expect 1 1c00
expect 2 2c00
expect 3 3c00
run
test prio_rr 1 00 20 0
beat 0 0d00
beat 1 1d00
beat 2 2d00
beat 3 3d00
expect 2 2d00
expect 3 3d00
expect 0 0d00
expect 1 1d00
run
test backpressure 2 b6 0 0
beat 0 0e01
beat 2 2e01
beat 0 0e02
beat 3 3e01
beat 2 2e02
beat 1 1e01
beat 0 0e03
beat 3 3e02
run
test stress_random 2 00 0 1
gen 12
run

// ==== compile.f ====
stream_merge_pkg.sv
stream_in_slice.sv
stream_arb_ctrl.sv
stream_path_switch.sv
stream_out_slice.sv
stream_merge_top.sv
stream_merge_tb.sv

// ==== Bender.yml ====
package:
  name: stream_merge

sources:
  - stream_merge_pkg.sv
  - stream_in_slice.sv
  - stream_arb_ctrl.sv
  - stream_path_switch.sv
  - stream_out_slice.sv
  - stream_merge_top.sv
  - target: test
    files:
      - stream_merge_tb.sv

// ==== stream_merge_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~
// stream merger testbench
// replays the vector file against the merger, stalls the sink
// and checks data, tags, order and round-robin fairness.
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
module stream_merge_tb #(
    parameter stream_merge_pkg::arb_mode_e tb_arb_mode = stream_merge_pkg::arb_fixed
);
    import stream_merge_pkg::*;

    localparam int    num_src     = 4;
    localparam int    data_w      = 16;
    localparam int    max_beats   = 64;
    localparam int    rng_seed    = 2;
    localparam string vector_file = "stream_merge_testdata.txt";

    logic               clock;
    logic               rst_n;
    logic [num_src-1:0] src_valid;
    logic [data_w-1:0]  src_data [num_src];
    logic [num_src-1:0] src_ready;
    logic               out_valid;
    logic [data_w-1:0]  out_data;
    logic [1:0]         out_source;
    logic               out_ready;

    logic [data_w-1:0] send_data [num_src][max_beats]; // offered beats, in per-source order.
    int                send_cnt [num_src];
    int                send_idx [num_src];
    int                exp_idx [num_src];
    int                skipped [num_src];
    logic [17:0]       ord_val [max_beats]; // {source, data} where the output order is fixed.
    int                ord_cnt;
    int                ord_idx;
    int                pending;
    logic [7:0]        stall_mask;
    int                hold_left;
    logic              rand_mode;
    string             test_name;
    int                error_count;
    int                checks_done;
    int                watch_limit;

    stream_merge_top #(
        .num_sources (num_src),
        .data_width  (data_w),
        .arb_mode    (tb_arb_mode)
    ) stream_merge_top_i (
        .clock      (clock),
        .rst_n      (rst_n),
        .src_valid  (src_valid),
        .src_data   (src_data),
        .src_ready  (src_ready),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_source (out_source),
        .out_ready  (out_ready)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = !clock;
    end

    task automatic add_beat(input int s, input logic [data_w-1:0] value);
        if (s >= 0 && s < num_src && send_cnt[s] < max_beats) begin
            send_data[s][send_cnt[s]] = value;
            send_cnt[s]++;
            pending++;
        end else begin
            $display("Error: a beat for source %0d does not fit the vector store", s);
            error_count++;
        end
    endtask

    task automatic check_reset_state();
        checks_done += 2;
        if (out_valid !== 1'b0) begin
            $display("Fail %s: out_valid expected 0 actual %b", test_name, out_valid);
            error_count++;
        end
        if (src_ready !== '1) begin
            $display("Fail %s: src_ready expected %b actual %b", test_name, {num_src{1'b1}},
                     src_ready);
            error_count++;
        end
    endtask

    task automatic count_vector_beats(output int total);
        int    fd;
        int    n;
        string line;
        string kw;

        total = 0;
        fd = $fopen(vector_file, "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                kw = "";
                n  = 0;
                void'($sscanf(line, "%s %d", kw, n));
                if (kw == "beat") total++;
                else if (kw == "gen") total += n * num_src;
            end
            $fclose(fd);
        end
    endtask

    // sources and sink are driven 1 ns after each rising edge.
    initial begin : drive_inputs
        logic [num_src-1:0] took;
        int                 seed;

        seed = rng_seed;
        void'($urandom(seed));
        forever begin
            @(posedge clock);
            took = src_valid & src_ready;
            #1;
            for (int s = 0; s < num_src; s++) begin
                if (took[s]) send_idx[s]++;
                // a raised valid stays up with the same data until its beat is taken.
                if (!src_valid[s] || took[s]) begin
                    src_valid[s] = (send_idx[s] < send_cnt[s]) &&
                                   (!rand_mode || $urandom_range(0, 2) != 0);
                    src_data[s]  = src_valid[s] ? send_data[s][send_idx[s]] : '0;
                end
            end
            if (hold_left > 0) begin
                out_ready = 1'b0;
                hold_left--;
            end else begin
                out_ready = !stall_mask[$time / 100 % 8] &&
                            (!rand_mode || $urandom_range(0, 3) != 0);
            end
        end
    end

    always @(posedge clock) begin
        int                 src;
        logic [num_src-1:0] acc;

        if (rst_n && out_valid && out_ready) begin
            src = out_source;
            checks_done++;
            if (exp_idx[src] >= send_cnt[src]) begin
                $display("Error: %s got a beat from source %0d that was never sent",
                         test_name, src);
                error_count++;
            end else begin
                if (out_data !== send_data[src][exp_idx[src]]) begin
                    $display("Fail %s: source %0d expected %h actual %h", test_name, src,
                             send_data[src][exp_idx[src]], out_data);
                    error_count++;
                end
                exp_idx[src]++;
                pending--;
            end
            if (ord_idx < ord_cnt) begin
                checks_done++;
                if ({out_source, out_data} !== ord_val[ord_idx]) begin
                    $display("Fail %s: beat %0d expected %h actual %h", test_name, ord_idx,
                             ord_val[ord_idx], {out_source, out_data});
                    error_count++;
                end
                ord_idx++;
            end
        end
        // a waiting slice may see at most num_src-1 grants to others before its own.
        acc = stream_merge_top_i.slice_valid & stream_merge_top_i.slice_ready;
        for (int s = 0; s < num_src; s++) begin
            if (!rst_n || !stream_merge_top_i.slice_valid[s] || acc[s]) begin
                skipped[s] = 0;
            end else if (acc != '0 && tb_arb_mode == arb_round_robin) begin
                skipped[s]++;
                if (skipped[s] == num_src) begin
                    $display("Error: %s passed over valid source %0d", test_name, s);
                    error_count++;
                end
            end
        end
    end

    initial begin : watchdog
        wait (watch_limit > 0);
        repeat (watch_limit) @(posedge clock);
        $display("Error: the run timed out after %0d cycles", watch_limit);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin : run_vectors
        int                total;
        int                fd;
        int                mode;
        int                hold;
        int                rnd;
        int                s;
        int                n;
        int                tests_run;
        logic [7:0]        mask;
        logic [data_w-1:0] value;
        logic              active;
        string             line;
        string             kw;
        string             name;

        rst_n      = 1'b0;
        src_valid  = '0;
        out_ready  = 1'b1;
        stall_mask = '0;
        hold_left  = 0;
        rand_mode  = 1'b0;
        pending    = 0;
        ord_cnt    = 0;
        ord_idx    = 0;
        test_name  = "reset";
        error_count = 0;
        checks_done = 0;
        watch_limit = 0;
        tests_run   = 0;
        active      = 1'b0;
        for (int i = 0; i < num_src; i++) begin
            src_data[i] = '0;
            send_cnt[i] = 0;
            send_idx[i] = 0;
            exp_idx[i]  = 0;
            skipped[i]  = 0;
        end
        for (int i = 0; i < 3; i++) begin
            @(posedge clock);
            #1;
            check_reset_state();
        end
        rst_n = 1'b1;
        @(posedge clock);
        @(negedge clock);
        check_reset_state(); // one edge after release nothing has arrived yet.

        count_vector_beats(total);
        watch_limit = total * 40 + 200;
        fd = $fopen(vector_file, "r");
        if (fd == 0) begin
            $display("Error: the vector file %s could not be opened", vector_file);
            error_count++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                kw = "";
                void'($sscanf(line, "%s", kw));
                if (kw == "test") begin
                    void'($sscanf(line, "%s %s %d %h %d %d", kw, name, mode, mask, hold, rnd));
                    active = (mode == 2) || (mode == int'(tb_arb_mode));
                    if (active) begin
                        test_name = name;
                        for (int i = 0; i < num_src; i++) begin
                            send_cnt[i] = 0;
                            send_idx[i] = 0;
                            exp_idx[i]  = 0;
                        end
                        ord_cnt    = 0;
                        ord_idx    = 0;
                        stall_mask = mask;
                        hold_left  = hold;
                        rand_mode  = (rnd != 0);
                    end
                end else if (active && kw == "beat") begin
                    void'($sscanf(line, "%s %d %h", kw, s, value));
                    add_beat(s, value);
                end else if (active && kw == "gen") begin
                    void'($sscanf(line, "%s %d", kw, n));
                    for (int k = 0; k < n; k++) begin
                        for (int j = 0; j < num_src; j++) begin
                            add_beat(j, data_w'(j * 4096 + k)); // source in the top nibble.
                        end
                    end
                end else if (active && kw == "expect" && ord_cnt < max_beats) begin
                    void'($sscanf(line, "%s %d %h", kw, s, value));
                    ord_val[ord_cnt] = {2'(s), value};
                    ord_cnt++;
                end else if (active && kw == "run") begin
                    tests_run++;
                    while (pending > 0) @(negedge clock);
                    stall_mask = '0;
                    rand_mode  = 1'b0;
                    repeat (20) @(negedge clock); // a stray extra beat would show up here.
                    $display("test %s done, %0d errors so far", test_name, error_count);
                    active = 1'b0;
                end
            end
            $fclose(fd);
        end

        $display("%0d errors in %0d checks over %0d tests", error_count, checks_done, tests_run);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== stream_merge_top.sv ====
//~~~~~~~~~~~~~~~~~~~~
// stream merger top level
// merges several valid/ready sources into one tagged stream.
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
module stream_merge_top #(
    parameter int                          num_sources = stream_merge_pkg::default_num_sources,
    parameter int                          data_width  = stream_merge_pkg::default_data_width,
    parameter stream_merge_pkg::arb_mode_e arb_mode    = stream_merge_pkg::arb_fixed,
    localparam int idx_width = (num_sources > 1) ? $clog2(num_sources) : 1
) (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic [num_sources-1:0] src_valid,
    input  logic [data_width-1:0]  src_data [num_sources],
    output logic [num_sources-1:0] src_ready,
    output logic                   out_valid,
    output logic [data_width-1:0]  out_data,
    output logic [idx_width-1:0]   out_source,
    input  logic                   out_ready
);

    logic [num_sources-1:0] slice_valid;
    logic [data_width-1:0]  slice_data [num_sources];
    logic [num_sources-1:0] slice_ready;
    logic                   sel_valid;
    logic [idx_width-1:0]   sel_source;
    logic [idx_width-1:0]   curr_path;
    logic                   sw_valid;
    logic [data_width-1:0]  sw_data;
    logic [idx_width-1:0]   sw_source;
    logic                   sw_ready;

    // one input slice per source.
    for (genvar i = 0; i < num_sources; i++) begin : g_in_slice
        stream_in_slice #(
            .data_width (data_width)
        ) stream_in_slice_i (
            .clock       (clock),
            .rst_n       (rst_n),
            .in_valid    (src_valid[i]),
            .in_data     (src_data[i]),
            .in_ready    (src_ready[i]),
            .slice_valid (slice_valid[i]),
            .slice_data  (slice_data[i]),
            .slice_ready (slice_ready[i])
        );
    end

    stream_arb_ctrl #(
        .num_sources (num_sources),
        .arb_mode    (arb_mode)
    ) stream_arb_ctrl_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .slice_valid (slice_valid),
        .slice_ready (slice_ready),
        .curr_path   (curr_path),
        .sel_valid   (sel_valid),
        .sel_source  (sel_source)
    );

    stream_path_switch #(
        .num_sources (num_sources),
        .data_width  (data_width)
    ) stream_path_switch_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .sel_valid   (sel_valid),
        .sel_source  (sel_source),
        .curr_path   (curr_path),
        .slice_valid (slice_valid),
        .slice_data  (slice_data),
        .slice_ready (slice_ready),
        .sw_valid    (sw_valid),
        .sw_data     (sw_data),
        .sw_source   (sw_source),
        .sw_ready    (sw_ready)
    );

    stream_out_slice #(
        .num_sources (num_sources),
        .data_width  (data_width)
    ) stream_out_slice_i (
        .clock      (clock),
        .rst_n      (rst_n),
        .sw_valid   (sw_valid),
        .sw_data    (sw_data),
        .sw_source  (sw_source),
        .sw_ready   (sw_ready),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_source (out_source),
        .out_ready  (out_ready)
    );

endmodule

// ==== stream_out_slice.sv ====
//~~~~~~~~~~~~~~~~~~~~
// stream output slice
// two-entry output register for data and source tag,
// with sw_ready taken from the fill count.
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
module stream_out_slice #(
    parameter int num_sources = stream_merge_pkg::default_num_sources,
    parameter int data_width  = stream_merge_pkg::default_data_width,
    localparam int idx_width = (num_sources > 1) ? $clog2(num_sources) : 1
) (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  sw_valid,
    input  logic [data_width-1:0] sw_data,
    input  logic [idx_width-1:0]  sw_source,
    output logic                  sw_ready,
    output logic                  out_valid,
    output logic [data_width-1:0] out_data,
    output logic [idx_width-1:0]  out_source,
    input  logic                  out_ready
);

    localparam int entry_width = idx_width + data_width;

    logic [entry_width-1:0] entry_q [2];
    logic                   wr_ptr;
    logic                   rd_ptr;
    logic [1:0]             count;
    logic                   push;
    logic                   pop;

    assign push = sw_valid && sw_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) wr_ptr <= !wr_ptr;
            if (pop)  rd_ptr <= !rd_ptr;
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count; // nothing moved, or one in and one out.
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            entry_q[wr_ptr] <= {sw_source, sw_data};
        end
    end

    assign sw_ready  = (count != 2'd2); // decoded straight from the count flops.
    assign out_valid = (count != 2'd0);
    assign {out_source, out_data} = entry_q[rd_ptr];

endmodule

// ==== stream_path_switch.sv ====
//~~~~~~~~~~~~~~~~~~~~
// stream path switch
// forwards the granted slice to the output slice,
// tags each beat with its source and routes ready back.
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
module stream_path_switch #(
    parameter int num_sources = stream_merge_pkg::default_num_sources,
    parameter int data_width  = stream_merge_pkg::default_data_width,
    localparam int idx_width = (num_sources > 1) ? $clog2(num_sources) : 1
) (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   sel_valid,
    input  logic [idx_width-1:0]   sel_source,
    output logic [idx_width-1:0]   curr_path,
    input  logic [num_sources-1:0] slice_valid,
    input  logic [data_width-1:0]  slice_data [num_sources],
    output logic [num_sources-1:0] slice_ready,
    output logic                   sw_valid,
    output logic [data_width-1:0]  sw_data,
    output logic [idx_width-1:0]   sw_source,
    input  logic                   sw_ready
);

    logic beat_move;

    assign beat_move = sw_valid && sw_ready;

    // The path only moves while no grant is confirmed. Beats flow only under
    // a confirmed grant, so nothing is in motion when the path changes.
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            curr_path <= '0;
        end else if (!sel_valid && !beat_move) begin
            curr_path <= sel_source;
        end
    end

    assign sw_valid  = sel_valid && slice_valid[curr_path];
    assign sw_data   = slice_data[curr_path];
    assign sw_source = curr_path; // the beat carries the number of its source.

    // only the slice on the current path ever sees ready.
    always_comb begin
        for (int i = 0; i < num_sources; i++) begin
            slice_ready[i] = sel_valid && sw_ready && (curr_path == idx_width'(i));
        end
    end

endmodule

// ==== stream_arb_ctrl.sv ====
//~~~~~~~~~~~~~~~~~~~~
// stream arbiter control
// locks onto one source until it has a beat accepted,
// then picks the next source by fixed priority or round robin.
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
module stream_arb_ctrl #(
    parameter int                          num_sources = stream_merge_pkg::default_num_sources,
    parameter stream_merge_pkg::arb_mode_e arb_mode    = stream_merge_pkg::arb_fixed,
    localparam int idx_width = (num_sources > 1) ? $clog2(num_sources) : 1
) (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic [num_sources-1:0] slice_valid,
    input  logic [num_sources-1:0] slice_ready,
    input  logic [idx_width-1:0]   curr_path,
    output logic                   sel_valid,
    output logic [idx_width-1:0]   sel_source
);
    import stream_merge_pkg::*;

    logic [num_sources-1:0] accepted;
    logic                   any_accept;
    logic                   lock;
    logic [num_sources-1:0] last_grant;
    logic [idx_width-1:0]   pick;

    assign accepted   = slice_valid & slice_ready;
    assign any_accept = |accepted;

    // An accepted beat releases the lock. Any pending source takes it again.
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            lock <= 1'b0;
        end else if (any_accept) begin
            lock <= 1'b0;
        end else if (|slice_valid) begin
            lock <= 1'b1;
        end
    end

    // one-hot record of the source that had the last beat accepted.
    // after reset the top source counts as last, so the search starts at source 0.
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            last_grant                <= '0;
            last_grant[num_sources-1] <= 1'b1;
        end else if (arb_mode == arb_round_robin && any_accept) begin
            last_grant <= accepted;
        end
    end

    always_comb begin
        int   last_idx;
        int   cand;
        logic found;

        last_idx = num_sources - 1;
        cand     = 0;
        found    = 1'b0;
        pick     = '0;
        if (arb_mode == arb_round_robin) begin
            for (int i = 0; i < num_sources; i++) begin
                if (last_grant[i]) begin
                    last_idx = i;
                end
            end
            // walk upwards from the source after the last grant, wrapping round.
            for (int k = 1; k <= num_sources; k++) begin
                cand = (last_idx + k) % num_sources;
                if (!found && slice_valid[cand]) begin
                    pick  = idx_width'(cand);
                    found = 1'b1;
                end
            end
        end else begin
            // the last hit of a downward scan is the lowest valid source.
            for (int i = num_sources - 1; i >= 0; i--) begin
                if (slice_valid[i]) begin
                    pick = idx_width'(i);
                end
            end
        end
    end

    // The choice follows the valids while unlocked and is frozen under the lock.
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            sel_source <= '0;
        end else if (!lock) begin
            sel_source <= pick;
        end
    end

    // the grant is confirmed once the switch reports the chosen path.
    // It drops right after the accept, so one lock moves one beat.
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            sel_valid <= 1'b0;
        end else begin
            sel_valid <= lock && !any_accept && (sel_source == curr_path);
        end
    end

endmodule

// ==== stream_in_slice.sv ====
//~~~~~~~~~~~~~~~~~~~~
// stream input slice
// two-entry register slice for one source.
// in_ready comes from a flop, so the ready path is broken.
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
module stream_in_slice #(
    parameter int data_width = stream_merge_pkg::default_data_width
) (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  logic [data_width-1:0] in_data,
    output logic                  in_ready,
    output logic                  slice_valid,
    output logic [data_width-1:0] slice_data,
    input  logic                  slice_ready
);

    logic                  main_valid;
    logic [data_width-1:0] main_data;
    logic                  skid_valid;
    logic [data_width-1:0] skid_data;
    logic                  main_free;

    // the main entry can load when it is empty or is being drained this cycle.
    assign main_free = !main_valid || slice_ready;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_free) begin
            main_valid <= skid_valid || in_valid; // the skid entry is older, it goes first.
            skid_valid <= 1'b0;
        end else if (in_valid && !skid_valid) begin
            skid_valid <= 1'b1;                   // the main entry is stuck, park the beat.
        end
    end

    always_ff @(posedge clock) begin
        if (main_free) begin
            main_data <= skid_valid ? skid_data : in_data;
        end
        if (!main_free && in_valid && !skid_valid) begin
            skid_data <= in_data;
        end
    end

    // a new beat is taken only while the skid entry is free.
    assign in_ready    = !skid_valid;
    assign slice_valid = main_valid;
    assign slice_data  = main_data;

endmodule

// ==== stream_merge_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~
// stream merger package
// default sizes and the arbitration policy
// shared by the merger blocks.
//~~~~~~~~~~~~~~~~~~~~
package stream_merge_pkg;

    // number of merged sources when the top level does not override it.
    localparam int default_num_sources = 32'd4;

    // width of one data beat in bits.
    localparam int default_data_width = 16;

    // arbitration policy of the control block.
    // arb_fixed gives the lowest-numbered valid source the grant.
    // arb_round_robin starts the search at the source after the last grant.
    typedef enum logic {
        arb_fixed       = 1'b0,
        arb_round_robin = 1'b1
    } arb_mode_e;

endpackage
